//--- filter_cfg_pkg.sv
//--------------------------------------------------------------------------
// Shared widths, configuration field layout and enums for the filter
// condition configuration collector. The configuration vector packs all
// fields from bit 0 upward, and each field takes the low bits of its word.
//--------------------------------------------------------------------------
package filter_cfg_pkg;

    //--------------------------------------------------------------------------
    // Response stream
    //--------------------------------------------------------------------------
    // One word per sequence index inside an engine window
    localparam int SEQ_WIDTH = 16;

    localparam int SEQ_IDX_W = 16;
    localparam int OFFSET_W  = 16;
    localparam int SHIFT_W   = 4;
    localparam int DATA_W    = 32;
    localparam int REL_IDX_W = 4;

    // Buffered word is the relative index on top of the data field
    localparam int RESP_W = REL_IDX_W + DATA_W;

    typedef logic [SEQ_IDX_W-1:0] seq_idx_t;
    typedef logic [OFFSET_W-1:0]  offset_t;
    typedef logic [SHIFT_W-1:0]   shift_t;
    typedef logic [DATA_W-1:0]    resp_data_t;
    typedef logic [REL_IDX_W-1:0] rel_idx_t;
    typedef logic [RESP_W-1:0]    resp_word_t;

    typedef enum logic [1:0] {
        CLASS_NONE         = 2'd0,
        CLASS_CU_SETUP     = 2'd1,
        CLASS_ENGINE_SETUP = 2'd2,
        CLASS_OTHER_DATA   = 2'd3
    } buffer_class_e;

    //--------------------------------------------------------------------------
    // Configuration fields
    //--------------------------------------------------------------------------
    localparam int NUM_FIELDS   = 4;
    localparam int FIELD_MASK_W = NUM_FIELDS;
    // One operator slot of NUM_FIELDS bits per field
    localparam int OPS_MASK_W   = NUM_FIELDS * NUM_FIELDS;
    localparam int ROUTE_W      = 8;
    localparam int OP_W         = 4;
    // break, continue, ternary, conditional from bit 0 up
    localparam int FLAGS_W      = 4;

    typedef logic [ROUTE_W-1:0] route_t;

    localparam int CFG_OP_LSB    = 0;
    localparam int CFG_FMASK_LSB = CFG_OP_LSB + OP_W;
    localparam int CFG_CMASK_LSB = CFG_FMASK_LSB + FIELD_MASK_W;
    localparam int CFG_CVAL_LSB  = CFG_CMASK_LSB + FIELD_MASK_W;
    localparam int CFG_OPS_LSB   = CFG_CVAL_LSB + DATA_W;
    localparam int CFG_FLAGS_LSB = CFG_OPS_LSB + OPS_MASK_W;
    localparam int CFG_IF_LSB    = CFG_FLAGS_LSB + FLAGS_W;
    localparam int CFG_ELSE_LSB  = CFG_IF_LSB + ROUTE_W;

    // Whole configuration, stored as one entry by the output FIFO
    localparam int CFG_W = CFG_ELSE_LSB + ROUTE_W;

    typedef logic [CFG_W-1:0] filter_cond_cfg_t;

    //--------------------------------------------------------------------------
    // Assembler FSM
    //--------------------------------------------------------------------------
    typedef enum logic [0:0] {
        ASM_COLLECT = 1'b0,
        ASM_EMIT    = 1'b1
    } asm_state_e;

endpackage : filter_cfg_pkg

//--- cfg_response_filter.sv
//--------------------------------------------------------------------------
// One-entry register stage in front of the response FIFO. Only setup
// words whose sequence index lies in this engine's window are kept, and
// everything else is consumed silently. The window must fit below
// 2**SEQ_IDX_W.
//--------------------------------------------------------------------------
module cfg_response_filter
    import filter_cfg_pkg::*;
#(
    parameter int ENGINE_SLOT = 0
) (
    input  logic          ap_clk,
    input  logic          areset_csr_index_generator,
    input  logic          resp_valid,
    output logic          resp_ready,
    input  buffer_class_e resp_class,
    input  offset_t       resp_offset,
    input  shift_t        resp_shift,
    input  resp_data_t    resp_data,
    output logic          kept_valid,
    input  logic          kept_ready,
    output resp_word_t    kept_word
);

    // Window bounds, upper bound exclusive
    localparam int unsigned WIN_LO = ENGINE_SLOT * SEQ_WIDTH;
    localparam int unsigned WIN_HI = WIN_LO + SEQ_WIDTH;

    seq_idx_t seq_idx;
    rel_idx_t rel_idx;
    logic     is_setup;
    logic     in_window;
    logic     keep;
    logic     accept;

    //--------------------------------------------------------------------------
    // Classification
    //--------------------------------------------------------------------------
    assign seq_idx  = seq_idx_t'(resp_offset >> resp_shift);
    assign is_setup = (resp_class == CLASS_CU_SETUP) || (resp_class == CLASS_ENGINE_SETUP);

    assign in_window = (32'(seq_idx) >= WIN_LO) && (32'(seq_idx) < WIN_HI);
    assign keep      = is_setup && in_window;

    // Offset from window start, fits REL_IDX_W once inside the window
    assign rel_idx = rel_idx_t'(seq_idx - seq_idx_t'(WIN_LO));

    //--------------------------------------------------------------------------
    // Output register
    //--------------------------------------------------------------------------
    // Register frees up in the same cycle it drains
    assign resp_ready = ~kept_valid | kept_ready;
    assign accept     = resp_valid & resp_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            kept_valid <= 1'b0;
        end else if (resp_ready) begin
            kept_valid <= resp_valid & keep;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept && keep) begin
            kept_word <= {rel_idx, resp_data};
        end
    end

endmodule : cfg_response_filter

//--- cfg_sync_fifo.sv
//--------------------------------------------------------------------------
// First-word-fall-through synchronous FIFO, valid/ready on both sides.
// Any DEPTH of 1 or more works. in_ready drops when full, so a push and a
// pop in the same cycle on a full FIFO only pops.
//--------------------------------------------------------------------------
module cfg_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Advance with wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    //--------------------------------------------------------------------------
    // Handshake
    //--------------------------------------------------------------------------
    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    // Head word is always on the output
    assign out_data = mem[rd_ptr];

    //--------------------------------------------------------------------------
    // Pointers and occupancy
    //--------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule : cfg_sync_fifo

//--- filter_cond_assembler.sv
//--------------------------------------------------------------------------
// Collects one word per relative index into a filter condition config.
// Indices 0 to 7 carry fields, 8 to 15 only need to arrive. Field values
// carry over into the next config until a new word overwrites them.
//--------------------------------------------------------------------------
module filter_cond_assembler
    import filter_cfg_pkg::*;
(
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             word_valid,
    output logic             word_ready,
    input  resp_word_t       word,
    output logic             cfg_push_valid,
    input  logic             cfg_push_ready,
    output filter_cond_cfg_t cfg_push
);

    asm_state_e           state;
    logic [SEQ_WIDTH-1:0] seen;
    logic [SEQ_WIDTH-1:0] seen_next;
    rel_idx_t             word_idx;
    resp_data_t           word_data;
    logic                 pop;

    // Field registers
    logic [OP_W-1:0]         op_code;
    logic [FIELD_MASK_W-1:0] filter_mask;
    logic [FIELD_MASK_W-1:0] const_mask;
    resp_data_t              const_value;
    logic [OPS_MASK_W-1:0]   ops_mask;
    logic [FLAGS_W-1:0]      flags;
    route_t                  if_route;
    route_t                  else_route;

    assign word_idx  = word[RESP_W-1 -: REL_IDX_W];
    assign word_data = word[DATA_W-1:0];

    //--------------------------------------------------------------------------
    // FSM and seen-set
    //--------------------------------------------------------------------------
    // Pop only while collecting, one word per cycle
    assign word_ready     = (state == ASM_COLLECT);
    assign pop            = word_valid & word_ready;
    assign cfg_push_valid = (state == ASM_EMIT);

    assign seen_next = seen | (SEQ_WIDTH'(1) << word_idx);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state <= ASM_COLLECT;
            seen  <= '0;
        end else begin
            case (state)
                ASM_COLLECT: begin
                    if (pop) begin
                        seen <= seen_next;
                        if (&seen_next) begin
                            state <= ASM_EMIT;
                        end
                    end
                end
                ASM_EMIT: begin
                    // Hold until the output FIFO takes it
                    if (cfg_push_ready) begin
                        seen  <= '0;
                        state <= ASM_COLLECT;
                    end
                end
                default: begin
                    state <= ASM_COLLECT;
                end
            endcase
        end
    end

    //--------------------------------------------------------------------------
    // Field decode
    //--------------------------------------------------------------------------
    // A repeated index simply overwrites its field
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            case (word_idx)
                4'd0: op_code     <= word_data[OP_W-1:0];
                4'd1: filter_mask <= word_data[FIELD_MASK_W-1:0];
                4'd2: const_mask  <= word_data[FIELD_MASK_W-1:0];
                4'd3: const_value <= word_data;
                4'd4: ops_mask    <= word_data[OPS_MASK_W-1:0];
                4'd5: flags       <= word_data[FLAGS_W-1:0];
                4'd6: if_route    <= word_data[ROUTE_W-1:0];
                4'd7: else_route  <= word_data[ROUTE_W-1:0];
                default: begin
                end
            endcase
        end
    end

    // Pack into the layout given by the package offsets
    always_comb begin
        cfg_push = '0;
        cfg_push[CFG_OP_LSB    +: OP_W]         = op_code;
        cfg_push[CFG_FMASK_LSB +: FIELD_MASK_W] = filter_mask;
        cfg_push[CFG_CMASK_LSB +: FIELD_MASK_W] = const_mask;
        cfg_push[CFG_CVAL_LSB  +: DATA_W]       = const_value;
        cfg_push[CFG_OPS_LSB   +: OPS_MASK_W]   = ops_mask;
        cfg_push[CFG_FLAGS_LSB +: FLAGS_W]      = flags;
        cfg_push[CFG_IF_LSB    +: ROUTE_W]      = if_route;
        cfg_push[CFG_ELSE_LSB  +: ROUTE_W]      = else_route;
    end

endmodule : filter_cond_assembler

//--- filter_cond_config_top.sv
//--------------------------------------------------------------------------
// Filter condition configuration collector. Latency from the last needed
// response to cfg_valid depends on how full both FIFOs are.
//--------------------------------------------------------------------------
module filter_cond_config_top
    import filter_cfg_pkg::*;
#(
    parameter int ENGINE_SLOT = 0,
    parameter int FIFO_DEPTH  = 16
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             resp_valid,
    output logic             resp_ready,
    input  buffer_class_e    resp_class,
    input  offset_t          resp_offset,
    input  shift_t           resp_shift,
    input  resp_data_t       resp_data,
    output logic             cfg_valid,
    input  logic             cfg_ready,
    output filter_cond_cfg_t cfg_data
);

    logic             kept_valid;
    logic             kept_ready;
    resp_word_t       kept_word;
    logic             word_valid;
    logic             word_ready;
    resp_word_t       word;
    logic             cfg_push_valid;
    logic             cfg_push_ready;
    filter_cond_cfg_t cfg_push;

    cfg_response_filter #(
        .ENGINE_SLOT(ENGINE_SLOT)
    ) filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_ready                (resp_ready),
        .resp_class                (resp_class),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .kept_valid                (kept_valid),
        .kept_ready                (kept_ready),
        .kept_word                 (kept_word)
    );

    cfg_sync_fifo #(
        .WIDTH(RESP_W),
        .DEPTH(FIFO_DEPTH)
    ) resp_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .in_valid                  (kept_valid),
        .in_ready                  (kept_ready),
        .in_data                   (kept_word),
        .out_valid                 (word_valid),
        .out_ready                 (word_ready),
        .out_data                  (word)
    );

    filter_cond_assembler assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .word_valid                (word_valid),
        .word_ready                (word_ready),
        .word                      (word),
        .cfg_push_valid            (cfg_push_valid),
        .cfg_push_ready            (cfg_push_ready),
        .cfg_push                  (cfg_push)
    );

    cfg_sync_fifo #(
        .WIDTH(CFG_W),
        .DEPTH(FIFO_DEPTH)
    ) cfg_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .in_valid                  (cfg_push_valid),
        .in_ready                  (cfg_push_ready),
        .in_data                   (cfg_push),
        .out_valid                 (cfg_valid),
        .out_ready                 (cfg_ready),
        .out_data                  (cfg_data)
    );

endmodule : filter_cond_config_top

//--- tb_filter_cond_config.sv
//--------------------------------------------------------------------------
// Testbench for the filter condition configuration collector, ENGINE_SLOT 1
// and FIFO_DEPTH 4. Stimulus rows are built into a table, and a reference
// model predicts every configuration. Field values carry over between
// windows, so the first window sets every field.
//--------------------------------------------------------------------------
module tb_filter_cond_config
    import filter_cfg_pkg::*;
;

    localparam int ENGINE_SLOT = 1;
    localparam int FIFO_DEPTH  = 4;
    localparam int WIN_LO      = ENGINE_SLOT * SEQ_WIDTH;
    localparam int NUM_TESTS   = 5;

    localparam int T_IN_ORDER = 0;
    localparam int T_SHUFFLED = 1;
    localparam int T_REJECT   = 2;
    localparam int T_REPEAT   = 3;
    localparam int T_BACKPRES = 4;

    typedef struct packed {
        logic [2:0]    test;
        buffer_class_e cls;
        offset_t       offset;
        shift_t        shift;
        resp_data_t    data;
        logic          done;
    } row_t;

    typedef struct packed {
        logic [2:0]       test;
        filter_cond_cfg_t cfg;
    } exp_t;

    logic             ap_clk = 1'b0;
    logic             areset_csr_index_generator;
    logic             resp_valid;
    logic             resp_ready;
    buffer_class_e    resp_class;
    offset_t          resp_offset;
    shift_t           resp_shift;
    resp_data_t       resp_data;
    logic             cfg_valid;
    logic             cfg_ready;
    filter_cond_cfg_t cfg_data;

    row_t             rows[$];
    exp_t             exp_q[$];
    exp_t             head;
    filter_cond_cfg_t model_cfg;
    logic [SEQ_WIDTH-1:0] model_seen;
    string            test_names [NUM_TESTS] = '{"in_order", "shuffled", "reject",
                                                 "repeat_index", "backpressure"};
    int               exp_count [NUM_TESTS];
    int               got_count [NUM_TESTS];
    int               test_err [NUM_TESTS];
    int               pass_tests;
    int               fail_tests;
    int               other_errs;
    int               cycles;
    int               cycle_limit;
    logic             bp_mode;
    logic             next_ready;
    logic [15:0]      lfsr;

    filter_cond_config_top #(
        .ENGINE_SLOT(ENGINE_SLOT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_ready                (resp_ready),
        .resp_class                (resp_class),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .cfg_valid                 (cfg_valid),
        .cfg_ready                 (cfg_ready),
        .cfg_data                  (cfg_data)
    );

    always #20 ap_clk = ~ap_clk;

    //--------------------------------------------------------------------------
    // Helpers
    //--------------------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Distinct data per key, every bit well mixed
    function automatic resp_data_t data_for(input int k);
        return resp_data_t'(32'h9E37_79B9 * (k + 1));
    endfunction

    task automatic write_field(input int rel, input resp_data_t d);
        case (rel)
            0: model_cfg[CFG_OP_LSB    +: OP_W]         = d[OP_W-1:0];
            1: model_cfg[CFG_FMASK_LSB +: FIELD_MASK_W] = d[FIELD_MASK_W-1:0];
            2: model_cfg[CFG_CMASK_LSB +: FIELD_MASK_W] = d[FIELD_MASK_W-1:0];
            3: model_cfg[CFG_CVAL_LSB  +: DATA_W]       = d;
            4: model_cfg[CFG_OPS_LSB   +: OPS_MASK_W]   = d[OPS_MASK_W-1:0];
            5: model_cfg[CFG_FLAGS_LSB +: FLAGS_W]      = d[FLAGS_W-1:0];
            6: model_cfg[CFG_IF_LSB    +: ROUTE_W]      = d[ROUTE_W-1:0];
            7: model_cfg[CFG_ELSE_LSB  +: ROUTE_W]      = d[ROUTE_W-1:0];
            default: ;
        endcase
    endtask

    // Append one row and run it through the reference model
    task automatic add_row(input int t, input buffer_class_e c, input int idx, input int sh,
                           input resp_data_t d, input bit done);
        row_t r;
        exp_t e;
        int   seq;
        bit   completes;
        r.test   = 3'(t);
        r.cls    = c;
        r.offset = offset_t'(idx << sh);
        r.shift  = shift_t'(sh);
        r.data   = d;
        r.done   = done;
        rows.push_back(r);
        seq       = int'(r.offset >> r.shift);
        completes = 1'b0;
        if ((c == CLASS_CU_SETUP || c == CLASS_ENGINE_SETUP) &&
            seq >= WIN_LO && seq < WIN_LO + SEQ_WIDTH) begin
            write_field(seq - WIN_LO, d);
            model_seen[seq - WIN_LO] = 1'b1;
            if (&model_seen) begin
                completes  = 1'b1;
                model_seen = '0;
                e.test     = 3'(t);
                e.cfg      = model_cfg;
                exp_q.push_back(e);
                exp_count[t]++;
            end
        end
        assert (completes == done) else begin
            $display("Row %0d of test %s: completion flag disagrees with the reference model",
                     rows.size() - 1, test_names[t]);
            other_errs++;
        end
    endtask

    task automatic build_table();
        int rel;
        for (int i = 0; i < SEQ_WIDTH; i++) begin
            add_row(T_IN_ORDER, CLASS_ENGINE_SETUP, WIN_LO + i, 0, data_for(i),
                    i == SEQ_WIDTH - 1);
        end
        // Stride 7 visits every index once, offset is index times 4
        for (int i = 0; i < SEQ_WIDTH; i++) begin
            rel = (i * 7 + 3) % SEQ_WIDTH;
            add_row(T_SHUFFLED, CLASS_CU_SETUP, WIN_LO + rel, 2, data_for(64 + rel),
                    i == SEQ_WIDTH - 1);
        end
        // Wrong class and out-of-window words after each good word
        for (int i = 0; i < SEQ_WIDTH; i++) begin
            add_row(T_REJECT, CLASS_ENGINE_SETUP, WIN_LO + i, 0, data_for(128 + i),
                    i == SEQ_WIDTH - 1);
            add_row(T_REJECT, (i % 2) ? CLASS_OTHER_DATA : CLASS_NONE, WIN_LO + i, 0,
                    ~data_for(128 + i), 1'b0);
            if (i < 8) begin
                // Same relative index one window below or above
                add_row(T_REJECT, CLASS_ENGINE_SETUP,
                        (i % 2) ? WIN_LO - SEQ_WIDTH + i : WIN_LO + SEQ_WIDTH + i, i % 4,
                        ~data_for(128 + i), 1'b0);
            end
        end
        for (int i = 0; i < SEQ_WIDTH; i++) begin
            add_row(T_REPEAT, CLASS_ENGINE_SETUP, WIN_LO + i, 0, data_for(192 + i),
                    i == SEQ_WIDTH - 1);
            if (i == 5) begin
                add_row(T_REPEAT, CLASS_ENGINE_SETUP, WIN_LO + 3, 0, data_for(255), 1'b0);
            end
        end
        for (int w = 0; w < 3; w++) begin
            for (int i = 0; i < SEQ_WIDTH; i++) begin
                add_row(T_BACKPRES, w[0] ? CLASS_CU_SETUP : CLASS_ENGINE_SETUP, WIN_LO + i, w,
                        data_for(256 + w * 16 + i), i == SEQ_WIDTH - 1);
            end
        end
    endtask

    task automatic send_row(input row_t r);
        resp_valid  = 1'b1;
        resp_class  = r.cls;
        resp_offset = r.offset;
        resp_shift  = r.shift;
        resp_data   = r.data;
        @(posedge ap_clk);
        while (!resp_ready) begin
            @(posedge ap_clk);
        end
        #1;
        resp_valid = 1'b0;
    endtask

    task automatic report_test(input int t);
        if (test_err[t] == 0) begin
            pass_tests++;
            $display("Test %s passed, %0d configurations", test_names[t], got_count[t]);
        end else begin
            fail_tests++;
            $display("Test %s failed, %0d mismatches", test_names[t], test_err[t]);
        end
    endtask

    //--------------------------------------------------------------------------
    // Output side
    //--------------------------------------------------------------------------
    // Random stalls only during the back-pressure test
    always @(posedge ap_clk) begin
        if (bp_mode) begin
            lfsr       = lfsr_step(lfsr);
            next_ready = lfsr[0];
        end else begin
            next_ready = 1'b1;
        end
        #1;
        cfg_ready = next_ready;
    end

    always @(posedge ap_clk) begin
        if (!areset_csr_index_generator && cfg_valid && cfg_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Configuration received when none was expected: %h", cfg_data);
                other_errs++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                got_count[head.test]++;
                assert (cfg_data === head.cfg) else begin
                    $display("ERROR test %s: expected %h, actual %h",
                             test_names[head.test], head.cfg, cfg_data);
                    test_err[head.test]++;
                end
                if (got_count[head.test] == exp_count[head.test]) begin
                    report_test(head.test);
                end
            end
        end
    end

    always @(posedge ap_clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //--------------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------------
    initial begin
        areset_csr_index_generator = 1'b1;
        resp_valid  = 1'b0;
        resp_class  = CLASS_NONE;
        resp_offset = '0;
        resp_shift  = '0;
        resp_data   = '0;
        cfg_ready   = 1'b1;
        bp_mode     = 1'b0;
        lfsr        = 16'd93;
        model_seen  = '0;
        cycles      = 0;
        build_table();
        cycle_limit = 40 * rows.size() + 200;
        repeat (2) @(posedge ap_clk);
        #1;
        areset_csr_index_generator = 1'b0;
        // Handshake state right after reset
        assert (resp_ready === 1'b1 && cfg_valid === 1'b0) else begin
            $display("Wrong state after reset: resp_ready %b, cfg_valid %b",
                     resp_ready, cfg_valid);
            other_errs++;
        end
        foreach (rows[i]) begin
            bp_mode = (rows[i].test == 3'(T_BACKPRES));
            send_row(rows[i]);
        end
        while (exp_q.size() != 0) begin
            @(posedge ap_clk);
        end
        // Idle window to catch any extra configuration
        repeat (20) @(posedge ap_clk);
        $display("Tests passed %0d, failed %0d, other errors %0d",
                 pass_tests, fail_tests, other_errs);
        if (fail_tests == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_filter_cond_config

//--- verilog.f
filter_cfg_pkg.sv
cfg_response_filter.sv
cfg_sync_fifo.sv
filter_cond_assembler.sv
filter_cond_config_top.sv
tb_filter_cond_config.sv

//--- Bender.yml
package:
  name: filter_cond_config

sources:
  - filter_cfg_pkg.sv
  - cfg_response_filter.sv
  - cfg_sync_fifo.sv
  - filter_cond_assembler.sv
  - filter_cond_config_top.sv
  - target: test
    files:
      - tb_filter_cond_config.sv
